/* Bender.yml */
package:
  name: weight_load

sources:
  - hdl/wl_pkg.sv
  - hdl/weight_load_decode.sv
  - hdl/weight_fetch_sequencer.sv
  - hdl/pe_enable_decoder.sv
  - hdl/weight_load_ctrl.sv
  - target: test
    files:
      - bench/weight_load_sva.sv
      - bench/weight_load_checker.sv
      - bench/weight_load_tb.sv

/* bench/weight_load_checker.sv */
`timescale 1ns/1ps

module weight_load_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_state_i,
    input  wl_pkg::layer_type_e layer_type_i,
    input  logic [31:0]         base_i,
    input  logic [31:0]         weight_addr_i,
    input  logic [7:0]          weight_i,
    input  wl_pkg::pe_en_t      pe_en_i,
    input  logic                load_done_i,
    input  logic                test_end_i,
    output int                  tests_o,
    output int                  failed_o,
    output int                  errs_o
);

    import wl_pkg::*;

    int          n; // edges sampled high in this load
    int          num;
    int          pe;
    int          test_errs;
    logic        ls_q;
    logic [31:0] exp_addr;
    logic        exp_done;
    pe_en_t      exp_en;
    pe_en_t      visited;
    pe_en_t      diag_mask;

    // PE of weight w as row*32+col
    function automatic int ref_pe(input layer_type_e lt, input int w);
        int c;
        c = w / 9;
        if (lt == layer_depthwise) return (3 * c + (w % 9) / 3) * 32 + 3 * c + w % 3;
        return w;
    endfunction

    function automatic int ref_num(input layer_type_e lt);
        case (lt)
            layer_pointwise, layer_linear: return 1024;
            layer_depthwise: return 90;
            default: return 0; // standard conv never loads
        endcase
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] addr);
        logic [31:0] word;
        word = weight_load_tb.glb_mem[addr[13:2]];
        return word[8 * addr[1:0] +: 8];
    endfunction

    initial begin
        tests_o = 0;
        failed_o = 0;
        errs_o = 0;
        test_errs = 0;
        diag_mask = '0;
        for (int r = 0; r < 30; r++) begin
            for (int c = 0; c < 30; c++) diag_mask[r][c] = (r / 3 == c / 3); // ten 3x3 blocks
        end
    end

    // outputs settle between edges
    always @(negedge clk) begin
        if (!rst_n) begin
            n = 0;
            ls_q = 1'b0;
        end else begin
            n = ls_q ? n + 1 : 0;
            ls_q = load_state_i;
            num = ref_num(layer_type_i);
            exp_en = '0;
            exp_addr = (n == 0) ? 32'h0 : base_i + n - 1;
            exp_done = (num != 0) && (n == num + 2);
            if (n >= 2 && n - 2 < num) begin
                pe = ref_pe(layer_type_i, n - 2);
                exp_en[pe / 32][pe % 32] = 1'b1;
                if (weight_i !== ref_byte(base_i + n - 2)) begin
                    $display("ERR weight_o n=%0d exp %h got %h", n, ref_byte(base_i + n - 2),
                             weight_i);
                    test_errs++;
                end
            end
            visited = (n == 0) ? '0 : (visited | pe_en_i);
            if (pe_en_i !== exp_en) begin
                $display("ERR pe_en_o n=%0d exp %h got %h", n, exp_en, pe_en_i);
                test_errs++;
            end
            if (weight_addr_i !== exp_addr) begin
                $display("ERR weight_addr_o n=%0d exp %h got %h", n, exp_addr, weight_addr_i);
                test_errs++;
            end
            if (load_done_i !== exp_done) begin
                $display("ERR load_done_o n=%0d exp %h got %h", n, exp_done, load_done_i);
                test_errs++;
            end
            if (layer_type_i == layer_depthwise && n == num + 2 && visited !== diag_mask) begin
                $display("depthwise load did not enable each diagonal PE exactly once");
                test_errs++;
            end
            if (test_end_i) begin
                tests_o++;
                errs_o += test_errs;
                if (test_errs != 0) failed_o++;
                $display("test %0d done with %0d errors", tests_o, test_errs);
                test_errs = 0;
            end
        end
    end

endmodule

/* bench/weight_load_sva.sv */
`timescale 1ns/1ps

module weight_load_sva (
    input logic           clk,
    input logic           rst_n,
    input logic           load_state_i,
    input logic           load_done_o,
    input wl_pkg::pe_en_t pe_en_o
);

    int fail_cnt = 0;

    a_one_pe: assert property (@(posedge clk) disable iff (!rst_n) $countones(pe_en_o) <= 1)
        else begin
            fail_cnt++;
            $error("more than one PE enabled in one cycle");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) load_done_o |=> !load_done_o)
        else begin
            fail_cnt++;
            $error("load_done_o high for more than one cycle");
        end

    // an edge that samples the level low clears the matrix
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !load_state_i |=> (pe_en_o == '0))
        else begin
            fail_cnt++;
            $error("pe_en_o set while no load is running");
        end

endmodule

bind weight_load_ctrl weight_load_sva i_weight_load_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_state_i (load_state_i),
    .load_done_o  (load_done_o),
    .pe_en_o      (pe_en_o)
);

/* bench/weight_load_tb.sv */
`timescale 1ns/1ps

module weight_load_tb;

    import wl_pkg::*;

    localparam int CLK_NS = 4;
    // two dense loads, three diagonal, two short ones, setup and margin
    localparam int RUN_CYCLES = 2 * (1024 + 8) + 3 * (90 + 8) + 2 * (40 + 8) + 16 + 200;

    logic        clk;
    logic        rst_n;
    logic        load_state;
    layer_type_e layer_type;
    logic [31:0] base_addr;
    logic [31:0] glb_rdata;
    logic [31:0] weight_addr;
    logic [7:0]  weight;
    pe_en_t      pe_en;
    logic        load_done;
    logic        test_end;
    logic [31:0] glb_mem [0:4095];
    int          tests;
    int          failed;
    int          errs;
    int          sva_fails;
    int          seed;

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // global buffer, one cycle of read latency
    always @(posedge clk) glb_rdata <= glb_mem[weight_addr[13:2]];

    weight_load_ctrl i_weight_load_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .load_state_i       (load_state),
        .layer_type_i       (layer_type),
        .weight_base_addr_i (base_addr),
        .glb_rdata_i        (glb_rdata),
        .weight_addr_o      (weight_addr),
        .weight_o           (weight),
        .pe_en_o            (pe_en),
        .load_done_o        (load_done)
    );

    weight_load_checker i_weight_load_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_state_i (load_state),
        .layer_type_i (layer_type),
        .base_i       (base_addr),
        .weight_addr_i(weight_addr),
        .weight_i     (weight),
        .pe_en_i      (pe_en),
        .load_done_i  (load_done),
        .test_end_i   (test_end),
        .tests_o      (tests),
        .failed_o     (failed),
        .errs_o       (errs)
    );

    // hold 0 runs until the done pulse
    task automatic run_load(input layer_type_e lt, input logic [31:0] base, input int hold);
        @(posedge clk);
        layer_type <= lt;
        base_addr <= base;
        @(posedge clk);
        load_state <= 1'b1;
        if (hold == 0) begin
            do begin
                @(posedge clk);
            end while (!load_done);
        end else begin
            repeat (hold) @(posedge clk);
        end
        load_state <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        seed = 516;
        void'($urandom(seed));
        for (int i = 0; i < 4096; i++) glb_mem[i] = $urandom() ^ i; // word index folded in
        rst_n = 1'b0;
        load_state = 1'b0;
        layer_type = layer_pointwise;
        base_addr = 32'h0;
        glb_rdata = 32'h0;
        test_end = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        end_test();
        run_load(layer_pointwise, 32'h0000_0103, 0);
        end_test();
        run_load(layer_depthwise, 32'h0000_0822, 0);
        end_test();
        run_load(layer_linear, 32'h0000_0401, 0);
        run_load(layer_depthwise, 32'h0000_0a0e, 0);
        end_test();
        run_load(layer_standard, 32'h0000_0300, 40);
        end_test();
        run_load(layer_depthwise, 32'h0000_0c05, 37); // dropped mid-load
        run_load(layer_depthwise, 32'h0000_0c05, 0);
        end_test();
        @(posedge clk);
        sva_fails = i_weight_load_ctrl.i_weight_load_sva.fail_cnt;
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests, failed, errs, sva_fails);
        if (tests == 6 && failed == 0 && errs == 0 && sva_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_NS);
        $display("watchdog expired before all loads finished");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* hdl/pe_enable_decoder.sv */
`timescale 1ns/1ps

module pe_enable_decoder #(
    parameter int KERNEL_DIM = wl_pkg::DEF_KERNEL_DIM
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  wl_pkg::load_plan_t          plan_i,
    input  logic [wl_pkg::IDX_W-1:0]    idx_i,
    input  logic                        idx_vld_i,
    input  wl_pkg::byte_lane_e          lane_i,
    input  logic [31:0]                 rdata_i,
    output wl_pkg::pe_en_t              pe_en_o,
    output logic [7:0]                  weight_o
);

    import wl_pkg::*;

    localparam int POS_W = $clog2(DEF_ARRAY_DIM);

    localparam logic [IDX_W-1:0] KD  = IDX_W'(KERNEL_DIM);
    localparam logic [IDX_W-1:0] KK  = IDX_W'(KERNEL_DIM * KERNEL_DIM);

    logic [IDX_W-1:0] chan;     // depthwise channel
    logic [IDX_W-1:0] tap;      // position inside the kernel
    logic [IDX_W-1:0] diag_row;
    logic [IDX_W-1:0] diag_col;
    logic [POS_W-1:0] pe_row;
    logic [POS_W-1:0] pe_col;

    // kernel c sits at rows and columns KERNEL_DIM*c upward
    always_comb begin
        chan     = idx_i / KK;
        tap      = idx_i % KK;
        diag_row = chan * KD + tap / KD;
        diag_col = chan * KD + tap % KD;
    end

    always_comb begin
        if (plan_i.mode == mode_diag) begin
            pe_row = diag_row[POS_W-1:0];
            pe_col = diag_col[POS_W-1:0];
        end else begin
            pe_row = idx_i[2*POS_W-1:POS_W]; // i*32+j
            pe_col = idx_i[POS_W-1:0];
        end
    end

    // one-hot, cleared on every cycle without a strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pe_en_o <= '0;
        end else begin
            pe_en_o <= '0;
            if (idx_vld_i && (plan_i.mode != mode_none)) begin
                pe_en_o[pe_row][pe_col] <= 1'b1;
            end
        end
    end

    // lane and read word arrive on the same edge
    always_comb begin
        case (lane_i)
            lane_b0: weight_o = rdata_i[7:0];
            lane_b1: weight_o = rdata_i[15:8];
            lane_b2: weight_o = rdata_i[23:16];
            lane_b3: weight_o = rdata_i[31:24];
            default: weight_o = 8'h00;
        endcase
    end

endmodule

/* hdl/weight_fetch_sequencer.sv */
`timescale 1ns/1ps

module weight_fetch_sequencer #(
    parameter int ADDR_W = wl_pkg::DEF_ADDR_W
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_state_i,
    input  wl_pkg::load_plan_t          plan_i,
    output logic [ADDR_W-1:0]           addr_o,
    output wl_pkg::byte_lane_e          lane_o,
    output logic [wl_pkg::IDX_W-1:0]    idx_o,
    output logic                        idx_vld_o,
    output logic                        done_o
);

    import wl_pkg::*;

    localparam logic [IDX_W-1:0] CNT_MAX = '1;

    logic [IDX_W-1:0] cycle_cnt; // edges sampled high in this load
    logic             idx_vld_q;
    logic [IDX_W-1:0] done_cnt;

    assign done_cnt = plan_i.count + 1'b1;

    // saturates so a long-held level cannot wrap into a second done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (!load_state_i) begin
            cycle_cnt <= '0;
        end else if (cycle_cnt != CNT_MAX) begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // byte address, base on the first edge of the load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_o <= '0;
        end else if (!load_state_i) begin
            addr_o <= '0;
        end else if (cycle_cnt == '0) begin
            addr_o <= plan_i.base[ADDR_W-1:0];
        end else begin
            addr_o <= addr_o + 1'b1;
        end
    end

    // one edge behind the address, same as the buffer read data
    always_ff @(posedge clk) begin
        lane_o <= byte_lane_e'(addr_o[1:0]);
    end

    always_ff @(posedge clk) begin
        idx_o <= cycle_cnt; // index w on edge w+1
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_vld_q <= 1'b0;
        end else begin
            idx_vld_q <= load_state_i && (cycle_cnt < plan_i.count);
        end
    end

    // an aborted load must not enable a PE on the edge that sees the drop
    assign idx_vld_o = idx_vld_q && load_state_i;

    // last enable went out one edge earlier
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o <= 1'b0;
        end else begin
            done_o <= load_state_i && (plan_i.mode != mode_none)
                      && (cycle_cnt == done_cnt);
        end
    end

endmodule

/* hdl/weight_load_ctrl.sv */
`timescale 1ns/1ps

module weight_load_ctrl #(
    parameter int ADDR_W      = wl_pkg::DEF_ADDR_W,
    parameter int KERNEL_DIM  = wl_pkg::DEF_KERNEL_DIM,
    parameter int DW_CHANNELS = wl_pkg::DEF_DW_CHANNELS
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_state_i,       // level, high for the load
    input  wl_pkg::layer_type_e layer_type_i,
    input  logic [ADDR_W-1:0]   weight_base_addr_i,
    input  logic [31:0]         glb_rdata_i,        // one cycle after the address
    output logic [ADDR_W-1:0]   weight_addr_o,
    output logic [7:0]          weight_o,
    output wl_pkg::pe_en_t      pe_en_o,
    output logic                load_done_o
);

    import wl_pkg::*;

    load_plan_t         plan;
    logic [IDX_W-1:0]   idx;
    logic               idx_vld;
    byte_lane_e         lane;

    // decode
    weight_load_decode #(
        .ADDR_W      (ADDR_W),
        .KERNEL_DIM  (KERNEL_DIM),
        .DW_CHANNELS (DW_CHANNELS)
    ) i_weight_load_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_state_i (load_state_i),
        .layer_type_i (layer_type_i),
        .base_addr_i  (weight_base_addr_i),
        .plan_o       (plan)
    );

    // execute
    weight_fetch_sequencer #(
        .ADDR_W (ADDR_W)
    ) i_weight_fetch_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_state_i (load_state_i),
        .plan_i       (plan),
        .addr_o       (weight_addr_o),
        .lane_o       (lane),
        .idx_o        (idx),
        .idx_vld_o    (idx_vld),
        .done_o       (load_done_o)
    );

    // result
    pe_enable_decoder #(
        .KERNEL_DIM (KERNEL_DIM)
    ) i_pe_enable_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .plan_i    (plan),
        .idx_i     (idx),
        .idx_vld_i (idx_vld),
        .lane_i    (lane),
        .rdata_i   (glb_rdata_i),
        .pe_en_o   (pe_en_o),
        .weight_o  (weight_o)
    );

endmodule

/* hdl/weight_load_decode.sv */
`timescale 1ns/1ps

module weight_load_decode #(
    parameter int ADDR_W      = wl_pkg::DEF_ADDR_W,
    parameter int KERNEL_DIM  = wl_pkg::DEF_KERNEL_DIM,
    parameter int DW_CHANNELS = wl_pkg::DEF_DW_CHANNELS
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_state_i,
    input  wl_pkg::layer_type_e layer_type_i,
    input  logic [ADDR_W-1:0]   base_addr_i,
    output wl_pkg::load_plan_t  plan_o
);

    import wl_pkg::*;

    localparam logic [IDX_W-1:0] DENSE_NUM = IDX_W'(DEF_ARRAY_DIM * DEF_ARRAY_DIM);
    localparam logic [IDX_W-1:0] DIAG_NUM  = IDX_W'(KERNEL_DIM * KERNEL_DIM * DW_CHANNELS);

    load_plan_t plan_d;

    always_comb begin
        plan_d.base = DEF_ADDR_W'(base_addr_i);
        case (layer_type_i)
            layer_pointwise, layer_linear: begin
                plan_d.mode  = mode_dense;
                plan_d.count = DENSE_NUM;
            end
            layer_depthwise: begin
                plan_d.mode  = mode_diag;
                plan_d.count = DIAG_NUM; // kernel taps times channels
            end
            default: begin
                // standard conv has no enable pattern
                plan_d.mode  = mode_none;
                plan_d.count = '0;
            end
        endcase
    end

    // sampled while idle, frozen once the load starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            plan_o <= '0;
        end else if (!load_state_i) begin
            plan_o <= plan_d;
        end
    end

endmodule

/* hdl/wl_pkg.sv */
package wl_pkg;

    // array geometry and layer defaults
    localparam int DEF_ARRAY_DIM   = 32;
    localparam int DEF_KERNEL_DIM  = 3;
    localparam int DEF_DW_CHANNELS = 10;
    localparam int DEF_ADDR_W      = 32;

    localparam int IDX_W = 11; // weight index and count, up to 1024 plus overrun

    // encoding shared with the layer scheduler
    typedef enum logic [1:0] {
        layer_pointwise = 2'd0,
        layer_depthwise = 2'd1,
        layer_standard  = 2'd2, // not loadable here
        layer_linear    = 2'd3
    } layer_type_e;

    typedef enum logic [1:0] {
        mode_none  = 2'd0,
        mode_dense = 2'd1, // full matrix, row-major
        mode_diag  = 2'd2  // kernels on the block diagonal
    } load_mode_e;

    // byte of the 32-bit read word that holds the weight
    typedef enum logic [1:0] {
        lane_b0 = 2'd0,
        lane_b1 = 2'd1,
        lane_b2 = 2'd2,
        lane_b3 = 2'd3
    } byte_lane_e;

    // held for the whole load
    typedef struct packed {
        load_mode_e             mode;
        logic [IDX_W-1:0]       count; // weights in the layer
        logic [DEF_ADDR_W-1:0]  base;  // byte address of weight 0
    } load_plan_t;

    // one enable bit per PE, indexed [row][col]
    typedef logic [DEF_ARRAY_DIM-1:0][DEF_ARRAY_DIM-1:0] pe_en_t;

endpackage

/* weight_load.f */
hdl/wl_pkg.sv
hdl/weight_load_decode.sv
hdl/weight_fetch_sequencer.sv
hdl/pe_enable_decoder.sv
hdl/weight_load_ctrl.sv
bench/weight_load_sva.sv
bench/weight_load_checker.sv
bench/weight_load_tb.sv
